// File: source/dsp_settings.svh
`ifndef DSP_SETTINGS_SVH
`define DSP_SETTINGS_SVH

`define DSP_WORD_W      16
`define DSP_INSN_W      24
`define DSP_PC_W        11
`define DSP_DP_W        8
`define DSP_STACK_DEPTH 16
`define DSP_OUT_CREDITS 4

// instruction class, insn[23:22]
`define DSP_CLS_OP 2'b00
`define DSP_CLS_RT 2'b01
`define DSP_CLS_JP 2'b10
`define DSP_CLS_LD 2'b11

// idb sources
`define DSP_SRC_A   4'h1
`define DSP_SRC_B   4'h2
`define DSP_SRC_TR  4'h3
`define DSP_SRC_DP  4'h4
`define DSP_SRC_SGN 4'h7
`define DSP_SRC_K   4'hd
`define DSP_SRC_L   4'he
`define DSP_SRC_MEM 4'hf

// destinations, OUT sits on the old DR code
`define DSP_DST_A   4'h1
`define DSP_DST_B   4'h2
`define DSP_DST_TR  4'h3
`define DSP_DST_DP  4'h4
`define DSP_DST_OUT 4'h6
`define DSP_DST_K   4'ha
`define DSP_DST_KLM 4'hc
`define DSP_DST_L   4'hd
`define DSP_DST_MEM 4'hf

`define DSP_DPL_INC 2'b01
`define DSP_DPL_DEC 2'b10
`define DSP_DPL_CLR 2'b11

// brch[8:6]
`define DSP_BR_COND 3'b010
`define DSP_BR_JMP  3'b100
`define DSP_BR_CALL 3'b101

`endif

// File: source/dsp_pkg.sv
`include "dsp_settings.svh"

package dsp_pkg;

  typedef logic [`DSP_WORD_W-1:0] word_t;
  typedef logic [`DSP_INSN_W-1:0] insn_t;
  typedef logic [`DSP_PC_W-1:0]   pc_t;
  typedef logic [`DSP_DP_W-1:0]   dp_t;

  typedef logic [3:0] alu_code_t;
  typedef logic [3:0] reg_code_t;  // src or dst code
  typedef logic [8:0] brch_t;

  typedef enum logic [1:0] {
    CLS_OP = `DSP_CLS_OP,
    CLS_RT = `DSP_CLS_RT,
    CLS_JP = `DSP_CLS_JP,
    CLS_LD = `DSP_CLS_LD
  } op_class_t;

  typedef enum logic [2:0] {
    FETCH,
    LOAD,
    ALU,
    STORE,
    WRITEBACK,
    IDLE
  } exec_state_t;

  // fields not used by a class stay zero
  typedef struct packed {
    op_class_t cls;
    logic [1:0] psel;
    alu_code_t  alu;
    logic       asl;   // 0 = A, 1 = B
    logic [1:0] dpl;
    logic [3:0] dphm;
    reg_code_t  src;
    reg_code_t  dst;
    brch_t      brch;
    pc_t        na;
    word_t      imm;
  } dec_t;

  typedef struct packed {
    logic s1;
    logic s0;
    logic c;
    logic z;
    logic ov1;
    logic ov0;
  } flags_t;

  typedef struct packed {
    flags_t b;
    flags_t a;
  } acc_flags_t;

endpackage

// File: source/dsp_pgm_mem.sv
`include "dsp_settings.svh"

module dsp_pgm_mem
  import dsp_pkg::*;
(
  input  logic  CLK,
  input  logic  pgm_we,
  input  pc_t   pgm_addr,
  input  insn_t pgm_data,
  input  pc_t   rd_addr,
  output insn_t rd_data
);

  insn_t mem [0:(1 << `DSP_PC_W)-1];

  always_ff @(posedge CLK) begin
    if (pgm_we) begin
      mem[pgm_addr] <= pgm_data;  // host load
    end
  end

  always_ff @(posedge CLK) begin
    rd_data <= mem[rd_addr];  // valid in FETCH
  end

endmodule

// File: source/dsp_data_ram.sv
`include "dsp_settings.svh"

module dsp_data_ram
  import dsp_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  dec_t        dec,
  input  exec_state_t state,
  input  word_t       idb,
  output dp_t         dp,
  output word_t       ram_q,
  output logic        dp_low_zero,
  output logic        dp_low_full
);

  word_t ram [0:(1 << `DSP_DP_W)-1];
  dp_t   rd_addr;
  logic  wr_en;

  // K-and-RAM load takes K from page dp | 0x40
  always_comb begin
    rd_addr = dp;
    if (state == ALU && dec.dst == `DSP_DST_KLM) begin
      rd_addr[7:4] = dp[7:4] | 4'b0100;
    end
  end

  assign wr_en = (state == WRITEBACK) && (dec.dst == `DSP_DST_MEM);

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      ram[dp] <= idb;
    end
    ram_q <= ram[rd_addr];
  end

  ////////////////////
  // data pointer

  always_ff @(posedge CLK) begin
    if (RST) begin
      dp <= '0;
    end else if (state == STORE && dec.dst == `DSP_DST_DP) begin
      dp <= idb[`DSP_DP_W-1:0];
    end else if (state == WRITEBACK) begin
      dp[7:4] <= dp[7:4] ^ dec.dphm;
      case (dec.dpl)
        `DSP_DPL_INC: dp[3:0] <= dp[3:0] + 4'd1;
        `DSP_DPL_DEC: dp[3:0] <= dp[3:0] - 4'd1;
        `DSP_DPL_CLR: dp[3:0] <= 4'd0;
        default:      dp[3:0] <= dp[3:0];
      endcase
    end
  end

  assign dp_low_zero = (dp[3:0] == 4'h0);
  assign dp_low_full = (dp[3:0] == 4'hf);

endmodule

// File: source/dsp_regs.sv
`include "dsp_settings.svh"

module dsp_regs
  import dsp_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  dec_t        dec,
  input  exec_state_t state,
  input  word_t       ram_q,
  input  word_t       acc_a,
  input  word_t       acc_b,
  input  dp_t         dp,
  input  logic        sat_sel,
  output word_t       idb,
  output word_t       mul_m,
  output word_t       mul_n
);

  localparam int PROD_W = 2 * `DSP_WORD_W;

  word_t                    reg_k;
  word_t                    reg_l;
  word_t                    reg_tr;
  word_t                    src_word;
  logic signed [PROD_W-1:0] prod;

  assign prod = $signed(reg_k) * $signed(reg_l);

  // idb source select
  always_comb begin
    case (dec.src)
      `DSP_SRC_A:   src_word = acc_a;
      `DSP_SRC_B:   src_word = acc_b;
      `DSP_SRC_TR:  src_word = reg_tr;
      `DSP_SRC_DP:  src_word = word_t'(dp);
      `DSP_SRC_SGN: src_word = sat_sel ? 16'h7fff : 16'h8000;
      `DSP_SRC_K:   src_word = reg_k;
      `DSP_SRC_L:   src_word = reg_l;
      `DSP_SRC_MEM: src_word = ram_q;
      default:      src_word = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      idb    <= '0;
      reg_k  <= '0;
      reg_l  <= '0;
      reg_tr <= '0;
      mul_m  <= '0;
      mul_n  <= '0;
    end else begin
      case (state)
        FETCH: begin
          mul_m <= {prod[31], prod[29:15]};  // Q15 high half
          mul_n <= {prod[14:0], 1'b0};
        end
        LOAD: begin
          idb <= (dec.cls == CLS_LD) ? dec.imm : src_word;
        end
        STORE: begin
          case (dec.dst)
            `DSP_DST_TR: reg_tr <= idb;
            `DSP_DST_K:  reg_k  <= idb;
            `DSP_DST_L:  reg_l  <= idb;
            `DSP_DST_KLM: begin
              reg_k <= ram_q;  // read from the upper page
              reg_l <= idb;
            end
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

// File: source/dsp_alu.sv
`include "dsp_settings.svh"

module dsp_alu
  import dsp_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  dec_t        dec,
  input  exec_state_t state,
  input  word_t       idb,
  input  word_t       ram_q,
  input  word_t       mul_m,
  input  word_t       mul_n,
  output word_t       acc_a,
  output word_t       acc_b,
  output acc_flags_t  flags,
  output logic        sat_sel
);

  word_t  alu_p;
  word_t  alu_q;
  word_t  alu_r;
  flags_t fl_cur;
  flags_t fl_new;
  logic   c_in;
  logic   arith;
  logic   ov;
  logic   direct_wr;

  assign fl_cur  = dec.asl ? flags.b : flags.a;
  assign c_in    = dec.asl ? flags.a.c : flags.b.c;  // other acc's carry
  assign sat_sel = flags.a.s1;

  // idb write to the same acc wins over the alu result
  assign direct_wr = (dec.dst == `DSP_DST_A && !dec.asl) ||
                     (dec.dst == `DSP_DST_B && dec.asl);

  ////////////////////
  // operands and result

  always_ff @(posedge CLK) begin
    if (state == ALU) begin
      alu_q <= dec.asl ? acc_b : acc_a;
      if (dec.alu[3:1] == 3'b100) begin
        alu_p <= word_t'(1);  // inc / dec
      end else begin
        case (dec.psel)
          2'b00:   alu_p <= ram_q;
          2'b01:   alu_p <= idb;
          2'b10:   alu_p <= mul_m;
          default: alu_p <= mul_n;
        endcase
      end
    end
    if (state == STORE) begin
      case (dec.alu)
        4'h1:       alu_r <= alu_q | alu_p;
        4'h2:       alu_r <= alu_q & alu_p;
        4'h3:       alu_r <= alu_q ^ alu_p;
        4'h4, 4'h8: alu_r <= alu_q - alu_p;
        4'h5, 4'h9: alu_r <= alu_q + alu_p;
        4'h6:       alu_r <= alu_q - alu_p - c_in;
        4'h7:       alu_r <= alu_q + alu_p + c_in;
        4'ha:       alu_r <= ~alu_q;
        4'hb:       alu_r <= {alu_q[15], alu_q[15:1]};
        4'hc:       alu_r <= {alu_q[14:0], c_in};
        4'hd:       alu_r <= {alu_q[13:0], 2'b11};
        4'he:       alu_r <= {alu_q[11:0], 4'hf};
        4'hf:       alu_r <= {alu_q[7:0], alu_q[15:8]};
        default:    alu_r <= alu_q;
      endcase
    end
  end

  ////////////////////
  // flags

  always_comb begin
    fl_new    = fl_cur;
    fl_new.z  = (alu_r == '0);
    fl_new.s0 = alu_r[15];
    arith     = 1'b0;
    ov        = 1'b0;
    case (dec.alu)
      4'h4, 4'h6, 4'h8: begin
        arith    = 1'b1;
        ov       = (alu_q[15] ^ alu_r[15]) & (alu_q[15] ^ alu_p[15]);
        fl_new.c = (alu_r > alu_q);  // borrow
      end
      4'h5, 4'h7, 4'h9: begin
        arith    = 1'b1;
        ov       = (alu_q[15] ^ alu_r[15]) & ~(alu_q[15] ^ alu_p[15]);
        fl_new.c = (alu_r < alu_q);
      end
      4'hb:    fl_new.c = alu_q[0];
      4'hc:    fl_new.c = alu_q[15];
      default: fl_new.c = 1'b0;
    endcase
    if (arith) begin
      fl_new.ov0 = ov;
      if (ov) begin
        // sticky pair, s1 holds the saturation direction
        fl_new.s1  = fl_cur.ov1 ^ ~alu_r[15];
        fl_new.ov1 = ~fl_cur.ov1;
      end
    end else begin
      fl_new.ov0 = 1'b0;
      fl_new.ov1 = 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      acc_a <= '0;
      acc_b <= '0;
      flags <= '0;
    end else if (state == STORE) begin
      if (dec.dst == `DSP_DST_A) acc_a <= idb;
      if (dec.dst == `DSP_DST_B) acc_b <= idb;
    end else if (state == WRITEBACK && dec.alu != 4'h0) begin
      if (dec.asl) begin
        flags.b <= fl_new;
        if (!direct_wr) acc_b <= alu_r;
      end else begin
        flags.a <= fl_new;
        if (!direct_wr) acc_a <= alu_r;
      end
    end
  end

endmodule

// File: source/dsp_sequencer.sv
`include "dsp_settings.svh"

module dsp_sequencer
  import dsp_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        run,
  input  insn_t       insn,
  input  word_t       idb,
  input  acc_flags_t  flags,
  input  logic        dp_low_zero,
  input  logic        dp_low_full,
  output pc_t         pc,
  output dec_t        dec,
  output exec_state_t state,
  output logic        out_valid,
  output word_t       out_data,
  input  logic        credit_return
);

  localparam int SP_W   = $clog2(`DSP_STACK_DEPTH);
  localparam int CRED_W = $clog2(`DSP_OUT_CREDITS + 1);

  logic [SP_W-1:0]   sp;
  logic [CRED_W-1:0] credits;
  pc_t               stack [0:`DSP_STACK_DEPTH-1];
  flags_t            fl_sel;
  logic              flag_bit;
  logic              jump_cond;
  logic              jump_taken;
  logic              is_out;
  logic              store_done;
  logic              push;

  function automatic dec_t decode(insn_t i);
    dec_t d;
    d     = '0;
    d.cls = op_class_t'(i[23:22]);
    case (d.cls)
      CLS_OP, CLS_RT: begin
        d.psel = i[21:20];
        d.alu  = i[19:16];
        d.asl  = i[15];
        d.dpl  = i[14:13];
        d.dphm = i[12:9];
        d.src  = i[7:4];
        d.dst  = i[3:0];
      end
      CLS_JP: begin
        d.brch = i[21:13];
        d.na   = i[12:2];
      end
      default: begin
        d.imm = i[21:6];
        d.dst = i[3:0];
      end
    endcase
    return d;
  endfunction

  ////////////////////
  // jump condition

  assign fl_sel = dec.brch[2] ? flags.b : flags.a;

  always_comb begin
    case (dec.brch[5:3])
      3'd0:    flag_bit = fl_sel.c;
      3'd1:    flag_bit = fl_sel.z;
      3'd2:    flag_bit = fl_sel.ov0;
      3'd3:    flag_bit = fl_sel.ov1;
      3'd4:    flag_bit = fl_sel.s0;
      default: flag_bit = fl_sel.s1;
    endcase
  end

  always_comb begin
    jump_cond = 1'b0;
    case (dec.brch[8:6])
      `DSP_BR_JMP, `DSP_BR_CALL: jump_cond = (dec.brch[5:0] == 6'd0);
      `DSP_BR_COND: begin
        if (dec.brch[5:2] == 4'b1100) begin  // dp low nibble
          jump_cond = (dec.brch[1] ? dp_low_full : dp_low_zero) ^ dec.brch[0];
        end else if (dec.brch[5:4] != 2'b11 && !dec.brch[0]) begin
          jump_cond = (flag_bit == dec.brch[1]);
        end
      end
      default: jump_cond = 1'b0;
    endcase
  end

  ////////////////////
  // output credits

  assign is_out     = (dec.dst == `DSP_DST_OUT);
  assign store_done = !is_out || (credits != '0);
  assign out_valid  = (state == STORE) && is_out && (credits != '0);
  assign out_data   = idb;

  assign push = (state == STORE) && (dec.cls == CLS_JP) && jump_taken &&
                (dec.brch[8:6] == `DSP_BR_CALL);

  always_ff @(posedge CLK) begin
    if (push) begin
      stack[sp] <= pc + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      state      <= IDLE;
      pc         <= '0;
      sp         <= '0;
      dec        <= '0;
      jump_taken <= 1'b0;
      credits    <= CRED_W'(`DSP_OUT_CREDITS);
    end else begin
      credits <= credits + CRED_W'(credit_return) - CRED_W'(out_valid);
      if (!run) begin
        state <= IDLE;
        pc    <= '0;
        sp    <= '0;
      end else begin
        case (state)
          IDLE: state <= FETCH;
          FETCH: begin
            dec   <= decode(insn);
            state <= LOAD;
          end
          LOAD: state <= ALU;
          ALU: begin
            jump_taken <= jump_cond;
            state      <= STORE;
          end
          STORE: begin
            if (store_done) begin  // OUT waits here for a credit
              state <= WRITEBACK;
              case (dec.cls)
                CLS_RT: begin
                  pc <= stack[sp - 1'b1];
                  sp <= sp - 1'b1;
                end
                CLS_JP: begin
                  pc <= jump_taken ? dec.na : pc + 1'b1;
                  if (push) sp <= sp + 1'b1;
                end
                default: pc <= pc + 1'b1;
              endcase
            end
          end
          default: state <= FETCH;
        endcase
      end
    end
  end

endmodule

// File: source/dsp_top.sv
module dsp_top
  import dsp_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  input  logic  run,
  input  logic  pgm_we,
  input  pc_t   pgm_addr,
  input  insn_t pgm_data,
  output logic  out_valid,
  output word_t out_data,
  input  logic  credit_return
);

  pc_t         pc;
  insn_t       insn;
  dec_t        dec;
  exec_state_t state;
  word_t       idb;
  word_t       ram_q;
  word_t       acc_a;
  word_t       acc_b;
  word_t       mul_m;
  word_t       mul_n;
  dp_t         dp;
  acc_flags_t  flags;
  logic        sat_sel;
  logic        dp_low_zero;
  logic        dp_low_full;

  dsp_sequencer u_seq (
    .CLK           (CLK),
    .RST           (RST),
    .run           (run),
    .insn          (insn),
    .idb           (idb),
    .flags         (flags),
    .dp_low_zero   (dp_low_zero),
    .dp_low_full   (dp_low_full),
    .pc            (pc),
    .dec           (dec),
    .state         (state),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .credit_return (credit_return)
  );

  dsp_pgm_mem u_pgm (
    .CLK      (CLK),
    .pgm_we   (pgm_we),
    .pgm_addr (pgm_addr),
    .pgm_data (pgm_data),
    .rd_addr  (pc),
    .rd_data  (insn)
  );

  dsp_regs u_regs (
    .CLK     (CLK),
    .RST     (RST),
    .dec     (dec),
    .state   (state),
    .ram_q   (ram_q),
    .acc_a   (acc_a),
    .acc_b   (acc_b),
    .dp      (dp),
    .sat_sel (sat_sel),
    .idb     (idb),
    .mul_m   (mul_m),
    .mul_n   (mul_n)
  );

  dsp_data_ram u_ram (
    .CLK         (CLK),
    .RST         (RST),
    .dec         (dec),
    .state       (state),
    .idb         (idb),
    .dp          (dp),
    .ram_q       (ram_q),
    .dp_low_zero (dp_low_zero),
    .dp_low_full (dp_low_full)
  );

  dsp_alu u_alu (
    .CLK     (CLK),
    .RST     (RST),
    .dec     (dec),
    .state   (state),
    .idb     (idb),
    .ram_q   (ram_q),
    .mul_m   (mul_m),
    .mul_n   (mul_n),
    .acc_a   (acc_a),
    .acc_b   (acc_b),
    .flags   (flags),
    .sat_sel (sat_sel)
  );

endmodule

// File: sim/dsp_model.svh
`ifndef DSP_MODEL_SVH
`define DSP_MODEL_SVH

insn_t  prog[$];
word_t  exp_words[$];
int     steps;
int     m_pc;
int     m_sp;
word_t  m_a, m_b, m_tr, m_k, m_l;
dp_t    m_dp;
flags_t m_fa, m_fb;
word_t  m_ram [0:255];
pc_t    m_stack [0:15];

function automatic insn_t ld_insn(word_t imm, logic [3:0] dst);
  return {2'b11, imm, 2'b00, dst};
endfunction

function automatic insn_t op_insn(logic [1:0] cls, logic [1:0] psel, logic [3:0] alu,
                                  logic asl, logic [1:0] dpl, logic [3:0] dphm,
                                  logic [3:0] src, logic [3:0] dst);
  return {cls, psel, alu, asl, dpl, dphm, 1'b0, src, dst};
endfunction

function automatic insn_t move_insn(logic [3:0] src, logic [3:0] dst);
  return op_insn(`DSP_CLS_OP, 2'b00, 4'h0, 1'b0, 2'b00, 4'h0, src, dst);
endfunction

function automatic insn_t jump_insn(logic [8:0] brch, int na);
  return {2'b10, brch, pc_t'(na), 2'b00};
endfunction

function automatic logic flag_of(flags_t f, logic [2:0] idx);
  case (idx)
    3'd0:    return f.c;
    3'd1:    return f.z;
    3'd2:    return f.ov0;
    3'd3:    return f.ov1;
    3'd4:    return f.s0;
    default: return f.s1;
  endcase
endfunction

function automatic word_t src_value(logic [3:0] src);
  case (src)
    `DSP_SRC_A:   return m_a;
    `DSP_SRC_B:   return m_b;
    `DSP_SRC_TR:  return m_tr;
    `DSP_SRC_DP:  return {8'h00, m_dp};
    `DSP_SRC_SGN: return m_fa.s1 ? 16'h7fff : 16'h8000;
    `DSP_SRC_K:   return m_k;
    `DSP_SRC_L:   return m_l;
    `DSP_SRC_MEM: return m_ram[m_dp];
    default:      return 16'h0000;
  endcase
endfunction

// result of one alu op, flags of the selected acc updated here
function automatic word_t alu_result(logic [3:0] op, logic asl, word_t p);
  word_t       q;
  word_t       r;
  flags_t      f;
  logic        cin;
  logic        arith;
  logic        ov;
  logic [16:0] wide;
  q     = asl ? m_b : m_a;
  f     = asl ? m_fb : m_fa;
  cin   = asl ? m_fa.c : m_fb.c;
  arith = 1'b0;
  ov    = 1'b0;
  f.c   = 1'b0;
  case (op)
    4'h1: r = q | p;
    4'h2: r = q & p;
    4'h3: r = q ^ p;
    4'h4, 4'h8: begin
      wide  = {1'b0, q} - {1'b0, p};
      r     = wide[15:0];
      f.c   = wide[16];  // borrow
      arith = 1'b1;
      ov    = (q[15] != p[15]) && (r[15] != q[15]);
    end
    4'h5, 4'h9: begin
      wide  = {1'b0, q} + {1'b0, p};
      r     = wide[15:0];
      f.c   = wide[16];
      arith = 1'b1;
      ov    = (q[15] == p[15]) && (r[15] != q[15]);
    end
    4'ha: r = ~q;
    4'hb: begin
      r   = {q[15], q[15:1]};
      f.c = q[0];
    end
    4'hc: begin
      r   = {q[14:0], cin};
      f.c = q[15];
    end
    4'hd: r = {q[13:0], 2'b11};
    4'he: r = {q[11:0], 4'hf};
    4'hf: r = {q[7:0], q[15:8]};
    default: r = q;
  endcase
  f.z  = (r == 16'h0000);
  f.s0 = r[15];
  if (arith) begin
    f.ov0 = ov;
    if (ov) begin
      f.s1  = f.ov1 ^ ~r[15];  // sticky pair
      f.ov1 = ~f.ov1;
    end
  end else begin
    f.ov0 = 1'b0;
    f.ov1 = 1'b0;
  end
  if (asl) m_fb = f;
  else m_fa = f;
  return r;
endfunction

task automatic step_insn(output logic halted);
  insn_t              i;
  logic signed [31:0] prod;
  word_t              mm, nn, val, p, r;
  logic [8:0]         brch;
  logic               taken;
  logic [3:0]         alu, dst;
  logic               asl;
  i      = prog[m_pc];
  halted = 1'b0;
  prod   = $signed(m_k) * $signed(m_l);
  mm     = {prod[31], prod[29:15]};
  nn     = {prod[14:0], 1'b0};
  if (i[23:22] == `DSP_CLS_JP) begin
    brch  = i[21:13];
    taken = 1'b0;
    if (brch[8:6] == `DSP_BR_JMP || brch[8:6] == `DSP_BR_CALL) begin
      taken = (brch[5:0] == 6'd0);
    end else if (brch[5:2] == 4'b1100) begin
      taken = (brch[1] ? (m_dp[3:0] == 4'hf) : (m_dp[3:0] == 4'h0)) ^ brch[0];
    end else begin
      taken = flag_of(brch[2] ? m_fb : m_fa, brch[5:3]) == brch[1];
    end
    if (taken && brch[8:6] == `DSP_BR_CALL) begin
      m_stack[m_sp] = pc_t'(m_pc + 1);
      m_sp = (m_sp + 1) % 16;
    end
    halted = taken && brch[8:6] == `DSP_BR_JMP && int'(i[12:2]) == m_pc;
    m_pc = taken ? int'(i[12:2]) : m_pc + 1;
    return;
  end
  val = (i[23:22] == `DSP_CLS_LD) ? i[21:6] : src_value(i[7:4]);
  dst = i[3:0];
  alu = (i[23:22] == `DSP_CLS_LD) ? 4'h0 : i[19:16];
  asl = i[15];
  case (i[21:20])
    2'b00:   p = m_ram[m_dp];
    2'b01:   p = val;
    2'b10:   p = mm;
    default: p = nn;
  endcase
  if (alu == 4'h8 || alu == 4'h9) p = 16'h0001;
  if (alu != 4'h0) r = alu_result(alu, asl, p);
  case (dst)
    `DSP_DST_A:   m_a = val;
    `DSP_DST_B:   m_b = val;
    `DSP_DST_TR:  m_tr = val;
    `DSP_DST_K:   m_k = val;
    `DSP_DST_L:   m_l = val;
    `DSP_DST_DP:  m_dp = val[7:0];
    `DSP_DST_OUT: exp_words.push_back(val);
    `DSP_DST_MEM: m_ram[m_dp] = val;
    default: ;
  endcase
  // a direct write to the same acc wins
  if (alu != 4'h0 && !(dst == `DSP_DST_A && !asl) && !(dst == `DSP_DST_B && asl)) begin
    if (asl) m_b = r;
    else m_a = r;
  end
  if (i[23:22] != `DSP_CLS_LD) begin
    m_dp[7:4] = m_dp[7:4] ^ i[12:9];
    case (i[14:13])
      `DSP_DPL_INC: m_dp[3:0] = m_dp[3:0] + 4'd1;
      `DSP_DPL_DEC: m_dp[3:0] = m_dp[3:0] - 4'd1;
      `DSP_DPL_CLR: m_dp[3:0] = 4'd0;
      default: ;
    endcase
  end
  if (i[23:22] == `DSP_CLS_RT) begin
    m_sp = (m_sp + 15) % 16;
    m_pc = int'(m_stack[m_sp]);
  end else begin
    m_pc = m_pc + 1;
  end
endtask

task automatic run_model();
  logic halted;
  m_pc   = 0;
  m_sp   = 0;
  steps  = 0;
  halted = 1'b0;
  exp_words.delete();
  while (!halted && steps < 4000) begin
    step_insn(halted);
    steps++;
  end
endtask

task automatic halt_here();
  prog.push_back(jump_insn({`DSP_BR_JMP, 6'd0}, prog.size()));
endtask

`endif

// File: sim/dsp_tb.sv
`include "dsp_settings.svh"

module dsp_tb
  import dsp_pkg::*;
;

  logic  CLK = 1'b0;
  logic  RST;
  logic  run;
  logic  pgm_we;
  pc_t   pgm_addr;
  insn_t pgm_data;
  logic  out_valid;
  word_t out_data;
  logic  credit_return;

  word_t got_words[$];
  int    tb_credits = `DSP_OUT_CREDITS;
  logic  withhold   = 1'b0;
  int    cycles     = 0;
  int    limit      = 100;
  int    errors     = 0;
  int    tests      = 0;

  `include "dsp_model.svh"

  dsp_top dut (
    .CLK           (CLK),
    .RST           (RST),
    .run           (run),
    .pgm_we        (pgm_we),
    .pgm_addr      (pgm_addr),
    .pgm_data      (pgm_data),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .credit_return (credit_return)
  );

  always #2 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////
  // consumer side

  always @(negedge CLK) begin
    if (!RST) begin
      if (out_valid) begin
        if (tb_credits == 0) begin
          $display("credit violation: out_valid high with no credit at cycle %0d", cycles);
          errors++;
        end
        got_words.push_back(out_data);
      end
      tb_credits = tb_credits + credit_return - out_valid;
    end
  end

  always @(posedge CLK) begin
    #1;
    credit_return = !RST && !withhold && tb_credits < `DSP_OUT_CREDITS &&
                    ($urandom % 3 == 0);
  end

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("[FAIL] %s: expected %0d words, actual %0d words", name, expected, actual);
      errors++;
    end
  endtask

  task automatic run_test(input string name, input int hold);
    int err0;
    int n;
    err0 = errors;
    run_model();
    limit += 5 * steps + 12 * exp_words.size() + prog.size() + hold + 200;
    got_words.delete();
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge CLK);
      #1;
      pgm_we   = 1'b1;
      pgm_addr = pc_t'(i);
      pgm_data = prog[i];
    end
    @(posedge CLK);
    withhold = (hold > 0);
    #1;
    pgm_we   = 1'b0;
    run      = 1'b1;
    if (hold > 0) begin
      repeat (hold) @(posedge CLK);
      withhold = 1'b0;
    end
    while (got_words.size() < exp_words.size()) @(posedge CLK);
    repeat (30) @(posedge CLK);  // catch extra words
    #1 run = 1'b0;
    @(posedge CLK);
    n = (got_words.size() < exp_words.size()) ? got_words.size() : exp_words.size();
    check_count(name, exp_words.size(), got_words.size());
    for (int i = 0; i < n; i++) check_word(name, exp_words[i], got_words[i]);
    $display("%s: %0d words, %s", name, got_words.size(),
             (errors == err0) ? "ok" : "mismatch");
    tests++;
  endtask

  ////////////////////
  // program builders

  task automatic load_move_prog();
    logic [3:0] dsts [5] = '{`DSP_DST_A, `DSP_DST_B, `DSP_DST_TR, `DSP_DST_K, `DSP_DST_L};
    logic [3:0] srcs [5] = '{`DSP_SRC_A, `DSP_SRC_B, `DSP_SRC_TR, `DSP_SRC_K, `DSP_SRC_L};
    prog.delete();
    foreach (dsts[i]) prog.push_back(ld_insn(word_t'($urandom), dsts[i]));
    foreach (srcs[i]) prog.push_back(move_insn(srcs[i], `DSP_DST_OUT));
    halt_here();
  endtask

  task automatic alu_flag_prog();
    logic [3:0] ops [13] = '{1, 2, 3, 4, 5, 8, 9, 10, 11, 12, 13, 14, 15};
    logic       asl;
    int         base;
    prog.delete();
    for (int t = 0; t < 8; t++) begin
      asl = $urandom % 2;
      prog.push_back(ld_insn(word_t'($urandom), `DSP_DST_A));
      prog.push_back(ld_insn(word_t'($urandom), `DSP_DST_B));
      prog.push_back(ld_insn(word_t'($urandom), `DSP_DST_TR));
      prog.push_back(op_insn(`DSP_CLS_OP, 2'(1 + $urandom % 3), ops[$urandom % 13], asl,
                             2'b00, 4'h0, `DSP_SRC_TR, 4'h0));
      prog.push_back(move_insn(asl ? `DSP_SRC_B : `DSP_SRC_A, `DSP_DST_OUT));
      for (int f = 0; f < 6; f++) begin
        base = prog.size();  // probe emits 1 when the flag is set
        prog.push_back(jump_insn({`DSP_BR_COND, 3'(f), asl, 2'b10}, base + 3));
        prog.push_back(ld_insn(16'h0000, `DSP_DST_OUT));
        prog.push_back(jump_insn({`DSP_BR_JMP, 6'd0}, base + 4));
        prog.push_back(ld_insn(16'h0001, `DSP_DST_OUT));
      end
    end
    halt_here();
  endtask

  task automatic multiply_prog();
    prog.delete();
    for (int t = 0; t < 4; t++) begin
      prog.push_back(ld_insn(word_t'($urandom), `DSP_DST_K));
      prog.push_back(ld_insn(word_t'($urandom), `DSP_DST_L));
      for (int h = 2; h < 4; h++) begin
        prog.push_back(ld_insn(16'h0000, `DSP_DST_A));
        prog.push_back(op_insn(`DSP_CLS_OP, 2'(h), 4'h1, 1'b0, 2'b00, 4'h0, 4'h0, 4'h0));
        prog.push_back(move_insn(`DSP_SRC_A, `DSP_DST_OUT));
      end
    end
    halt_here();
  endtask

  task automatic loop_call_prog();
    prog.delete();
    prog.push_back(ld_insn({8'h00, 4'($urandom), 4'(3 + $urandom % 6)}, `DSP_DST_DP));
    prog.push_back(op_insn(`DSP_CLS_OP, 2'b00, 4'h0, 1'b0, `DSP_DPL_DEC, 4'h0,
                           `DSP_SRC_DP, `DSP_DST_OUT));
    prog.push_back(jump_insn({`DSP_BR_COND, 4'b1100, 2'b01}, 1));  // until dp low is 0
    prog.push_back(jump_insn({`DSP_BR_CALL, 6'd0}, 6));
    prog.push_back(ld_insn(16'h1234, `DSP_DST_OUT));
    halt_here();
    prog.push_back(ld_insn(16'habcd, `DSP_DST_OUT));
    prog.push_back(op_insn(`DSP_CLS_RT, 2'b00, 4'h0, 1'b0, 2'b00, 4'h0, 4'h0, 4'h0));
  endtask

  task automatic ram_walk_prog();
    logic [3:0] masks [6];
    word_t      base;
    base = word_t'($urandom % 256);
    prog.delete();
    prog.push_back(ld_insn(base, `DSP_DST_DP));
    foreach (masks[i]) begin
      masks[i] = 4'($urandom);
      prog.push_back(ld_insn(word_t'($urandom), `DSP_DST_TR));
      prog.push_back(op_insn(`DSP_CLS_OP, 2'b00, 4'h0, 1'b0, `DSP_DPL_INC, masks[i],
                             `DSP_SRC_TR, `DSP_DST_MEM));
    end
    prog.push_back(ld_insn(base, `DSP_DST_DP));
    foreach (masks[i]) begin
      prog.push_back(op_insn(`DSP_CLS_OP, 2'b00, 4'h0, 1'b0, `DSP_DPL_INC, masks[i],
                             `DSP_SRC_MEM, `DSP_DST_OUT));
    end
    halt_here();
  endtask

  task automatic burst_prog();
    prog.delete();
    for (int i = 0; i < 10; i++) prog.push_back(ld_insn(word_t'($urandom), `DSP_DST_OUT));
    halt_here();
  endtask

  initial begin
    void'($urandom(92));
    RST           = 1'b1;
    run           = 1'b0;
    pgm_we        = 1'b0;
    pgm_addr      = '0;
    pgm_data      = '0;
    credit_return = 1'b0;
    {m_a, m_b, m_tr, m_k, m_l} = '0;
    m_dp = '0;
    m_fa = '0;
    m_fb = '0;
    repeat (3) @(posedge CLK);
    #1 RST = 1'b0;

    load_move_prog();
    run_test("load_move", 0);
    alu_flag_prog();
    run_test("alu_flags", 0);
    multiply_prog();
    run_test("multiply", 0);
    loop_call_prog();
    run_test("loop_call", 0);
    ram_walk_prog();
    run_test("ram_walk", 0);
    burst_prog();
    run_test("back_pressure", 120);

    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: Bender.yml
package:
  name: dsp_core

sources:
  - include_dirs:
      - source
    files:
      - source/dsp_pkg.sv
      - source/dsp_pgm_mem.sv
      - source/dsp_data_ram.sv
      - source/dsp_regs.sv
      - source/dsp_alu.sv
      - source/dsp_sequencer.sv
      - source/dsp_top.sv
  - target: simulation
    include_dirs:
      - source
      - sim
    files:
      - sim/dsp_tb.sv

// File: sources.f
+incdir+source
+incdir+sim
source/dsp_pkg.sv
source/dsp_pgm_mem.sv
source/dsp_data_ram.sv
source/dsp_regs.sv
source/dsp_alu.sv
source/dsp_sequencer.sv
source/dsp_top.sv
sim/dsp_tb.sv
